// File: src.f
+incdir+tests
common/isaPkg.sv
common/execPkg.sv
common/stageIf.sv
logic/handshakeCtrl.sv
decode/instDecoder.sv
execute/aluExecute.sv
logic/resultStage.sv
logic/rvExecTop.sv
tests/rvExecTb.sv

// File: run.sh
#!/bin/sh
# build and run the RV64I execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module rvExecTb -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: tests/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

typedef struct packed {
    logic        rdWrite;
    logic [63:0] rdData;
    logic [63:0] nextPc;
    logic [63:0] memAddr;
    logic        memRead;
    logic [3:0]  loadSize;
    logic        loadSigned;
    logic [7:0]  storeMask;
    logic        illegal;
} expectT;

function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

function automatic logic legalInst(input logic [31:0] inst);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = inst[14:12];
    f7 = inst[31:25];
    case (inst[6:0])
        7'b0110011: return f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
        7'b0010011: begin
            if (f3 == 3'd1)
                return inst[31:26] == 6'h00; // 6-bit shamt on rv64
            if (f3 == 3'd5)
                return inst[31:26] == 6'h00 || inst[31:26] == 6'h10;
            return 1'b1;
        end
        7'b0111011: return (f7 == 7'h00 && f3 inside {3'd0, 3'd1, 3'd5})
            || (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
        7'b0011011: begin
            if (f3 == 3'd0)
                return 1'b1; // addiw, top bits are imm
            return (f3 == 3'd1 && f7 == 7'h00) || (f3 == 3'd5 && f7 inside {7'h00, 7'h20});
        end
        7'b0110111, 7'b0010111, 7'b1101111: return 1'b1; // lui auipc jal
        7'b1100111: return f3 == 3'd0;
        7'b1100011: return !(f3 inside {3'd2, 3'd3});
        7'b0000011: return f3 != 3'd7;
        7'b0100011: return !f3[2];
        default:    return 1'b0; // system, fence, unknown
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [63:0] a,
                                     input logic [63:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

function automatic logic [63:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [63:0] a, input logic [63:0] b,
                                         input logic word);
    logic [5:0]  sh;
    logic [31:0] lo;
    sh = word ? {1'b0, b[4:0]} : b[5:0];
    if (word) begin
        case (f3)
            3'd0: lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
            3'd1: lo = a[31:0] << sh;
            default: begin
                if (alt)
                    lo = $signed(a[31:0]) >>> sh;
                else
                    lo = a[31:0] >> sh;
            end
        endcase
        return sext32(lo);
    end
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << sh;
        3'd2: return {63'b0, $signed(a) < $signed(b)};
        3'd3: return {63'b0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt)
                return $signed(a) >>> sh;
            return a >> sh;
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic expectT modelInst(input logic [31:0] inst, input logic [63:0] pc,
                                     input logic [63:0] rs1, input logic [63:0] rs2);
    expectT e;
    logic [2:0] f3;
    logic [63:0] immI, immS, immB, immU, immJ;
    f3 = inst[14:12];
    immI = {{52{inst[31]}}, inst[31:20]};
    immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    immB = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    immU = {{32{inst[31]}}, inst[31:12], 12'h000};
    immJ = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    e = '0;
    e.nextPc = pc + 64'd4;
    e.illegal = !legalInst(inst);
    if (e.illegal)
        return e;
    case (inst[6:0])
        7'b0110011: e.rdData = aluModel(f3, inst[30], rs1, rs2, 1'b0);
        7'b0010011: e.rdData = aluModel(f3, f3 == 3'd5 && inst[30], rs1, immI, 1'b0);
        7'b0111011: e.rdData = aluModel(f3, inst[30], rs1, rs2, 1'b1);
        7'b0011011: e.rdData = aluModel(f3, f3 == 3'd5 && inst[30], rs1, immI, 1'b1);
        7'b0110111: e.rdData = immU;
        7'b0010111: e.rdData = pc + immU;
        7'b1101111: begin
            e.rdData = pc + 64'd4;
            e.nextPc = pc + immJ;
        end
        7'b1100111: begin
            e.rdData = pc + 64'd4;
            e.nextPc = (rs1 + immI) & ~64'd1;
        end
        7'b1100011: begin
            if (branchTaken(f3, rs1, rs2))
                e.nextPc = pc + immB;
        end
        7'b0000011: begin
            e.memRead = 1'b1;
            e.memAddr = rs1 + immI;
            e.loadSize = 4'd1 << f3[1:0];
            e.loadSigned = !f3[2]; // lbu lhu lwu are unsigned
        end
        default: begin
            e.memAddr = rs1 + immS;
            case (f3[1:0])
                2'd0:    e.storeMask = 8'h01;
                2'd1:    e.storeMask = 8'h03;
                2'd2:    e.storeMask = 8'h0f;
                default: e.storeMask = 8'hff;
            endcase
        end
    endcase
    e.rdWrite = inst[6:0] inside {7'b0110011, 7'b0010011, 7'b0111011, 7'b0011011,
                                  7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111};
    return e;
endfunction

`endif

// File: tests/rvExecTb.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecTb;

    localparam int numTests = 400;
    localparam int resetCycles = 10;
    localparam int timeoutCycles = numTests * 20 + resetCycles;

    logic        clk;
    logic        reset;
    logic        req;
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rs1;
    logic [63:0] rs2;
    logic        ack;
    logic        rdWrite;
    logic [63:0] rdData;
    logic [63:0] nextPc;
    logic [63:0] memAddr;
    logic        memRead;
    logic [3:0]  loadSize;
    logic        loadSigned;
    logic [7:0]  storeMask;
    logic        illegal;
    integer      seed;

    `include "refModel.svh"

    rvExecTop DUT (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .inst       (inst),
        .pc         (pc),
        .rs1        (rs1),
        .rs2        (rs2),
        .ack        (ack),
        .rdWrite    (rdWrite),
        .rdData     (rdData),
        .nextPc     (nextPc),
        .memAddr    (memAddr),
        .memRead    (memRead),
        .loadSize   (loadSize),
        .loadSigned (loadSigned),
        .storeMask  (storeMask),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic logic [31:0] makeInst();
        logic [31:0] w;
        logic        alt;
        int          kind;
        w = $random(seed);
        alt = w[30];
        kind = randBelow(12);
        case (kind)
            0: begin
                w[6:0] = 7'b0110011;
                w[31:25] = (alt && w[14:12] inside {3'd0, 3'd5}) ? 7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = 7'b0010011;
                if (w[14:12] == 3'd1)
                    w[31:26] = 6'h00;
                else if (w[14:12] == 3'd5)
                    w[31:26] = {1'b0, alt, 4'h0}; // srli or srai
            end
            2, 3: begin
                w[6:0] = kind == 2 ? 7'b0111011 : 7'b0011011;
                w[14:12] = w[13] ? 3'd5 : {2'b00, w[12]};
                w[31:25] = (alt && w[14:12] != 3'd1) ? 7'h20 : 7'h00;
            end
            4: w[6:0] = 7'b0110111;
            5: w[6:0] = 7'b0010111;
            6: w[6:0] = 7'b1101111;
            7: begin
                w[6:0] = 7'b1100111;
                w[14:12] = 3'd0;
            end
            8: begin
                w[6:0] = 7'b1100011;
                if (w[14:13] == 2'b01)
                    w[13] = 1'b0; // no branch on 010/011
            end
            9: begin
                w[6:0] = 7'b0000011;
                if (w[14:12] == 3'd7)
                    w[14] = 1'b0;
            end
            10: begin
                w[6:0] = 7'b0100011;
                w[14] = 1'b0;
            end
            default: begin
                if (alt)
                    w[6:0] = 7'b1110011; // system
            end
        endcase
        return w;
    endfunction

    function automatic expectT observed();
        expectT o;
        o.rdWrite = rdWrite;
        o.rdData = rdData;
        o.nextPc = nextPc;
        o.memAddr = memAddr;
        o.memRead = memRead;
        o.loadSize = loadSize;
        o.loadSigned = loadSigned;
        o.storeMask = storeMask;
        o.illegal = illegal;
        return o;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // all set compares every output against a snapshot
    task automatic checkOutputs(input expectT want, input logic all);
        checkValue("illegal", 64'(want.illegal), 64'(illegal));
        checkValue("rdWrite", 64'(want.rdWrite), 64'(rdWrite));
        if (all || want.rdWrite)
            checkValue("rdData", want.rdData, rdData);
        checkValue("nextPc", want.nextPc, nextPc);
        if (all || want.memRead || want.storeMask != 8'h00)
            checkValue("memAddr", want.memAddr, memAddr);
        checkValue("memRead", 64'(want.memRead), 64'(memRead));
        checkValue("loadSize", 64'(want.loadSize), 64'(loadSize));
        checkValue("loadSigned", 64'(want.loadSigned), 64'(loadSigned));
        checkValue("storeMask", 64'(want.storeMask), 64'(storeMask));
    endtask

    task automatic runOne();
        expectT want;
        expectT snap;
        int     cycles;
        int     hold;
        inst = makeInst();
        pc = {$random(seed), $random(seed)} & ~64'd3;
        rs1 = {$random(seed), $random(seed)};
        rs2 = randBelow(4) == 0 ? rs1 : {$random(seed), $random(seed)}; // equal operands
        want = modelInst(inst, pc, rs1, rs2);
        req = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack);
        checkValue("ackLatency", 64'd5, 64'(cycles));
        checkOutputs(want, 1'b0);
        snap = observed();
        inst = $random(seed); // requester is free once ack is seen
        rs1 = {$random(seed), $random(seed)};
        hold = randBelow(4);
        repeat (hold) begin
            @(negedge clk);
            checkValue("ack", 64'd1, 64'(ack));
            checkOutputs(snap, 1'b1);
        end
        req = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack);
        checkValue("ackRelease", 64'd1, 64'(cycles));
        checkOutputs(snap, 1'b1);
    endtask

    initial begin
        seed = 84803;
        reset = 1'b1;
        req = 1'b0;
        inst = '0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue("ack", 64'd0, 64'(ack));
        for (int i = 0; i < numTests; i++)
            runOne();
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Something failed");
        $fatal(1, "handshake timed out after %0d cycles", timeoutCycles);
    end

endmodule

`default_nettype wire

// File: logic/rvExecTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvExecTop import isaPkg::*, execPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req,
    input  logic [31:0]               inst,
    input  logic [xlen-1:0]           pc,
    input  logic [xlen-1:0]           rs1,
    input  logic [xlen-1:0]           rs2,
    output logic                      ack,
    output logic                      rdWrite,
    output logic [xlen-1:0]           rdData,
    output logic [xlen-1:0]           nextPc,
    output logic [xlen-1:0]           memAddr,
    output logic                      memRead,
    output logic [loadSizeWidth-1:0]  loadSize,
    output logic                      loadSigned,
    output logic [storeMaskWidth-1:0] storeMask,
    output logic                      illegal
);

    logic start;
    logic done;

    decodeIf  decBus ();
    executeIf exeBus ();

    handshakeCtrl ctrl (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .done  (done),
        .start (start),
        .ack   (ack)
    );

    instDecoder decoder (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .inst  (inst),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .dec   (decBus)
    );

    aluExecute execute (
        .clk   (clk),
        .reset (reset),
        .dec   (decBus),
        .exe   (exeBus)
    );

    resultStage result (
        .clk        (clk),
        .reset      (reset),
        .exe        (exeBus),
        .done       (done),
        .rdWrite    (rdWrite),
        .rdData     (rdData),
        .nextPc     (nextPc),
        .memAddr    (memAddr),
        .memRead    (memRead),
        .loadSize   (loadSize),
        .loadSigned (loadSigned),
        .storeMask  (storeMask),
        .illegal    (illegal)
    );

endmodule

`default_nettype wire

// File: logic/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage import isaPkg::*, execPkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    executeIf.consumer                exe,
    output logic                      done,
    output logic                      rdWrite,
    output logic [xlen-1:0]           rdData,
    output logic [xlen-1:0]           nextPc,
    output logic [xlen-1:0]           memAddr,
    output logic                      memRead,
    output logic [loadSizeWidth-1:0]  loadSize,
    output logic                      loadSigned,
    output logic [storeMaskWidth-1:0] storeMask,
    output logic                      illegal
);

    logic [xlen-1:0] wbValue;

    assign wbValue = exe.wbSel == wbLink ? exe.linkValue : exe.aluResult;

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
            rdWrite <= 1'b0;
            memRead <= 1'b0;
            storeMask <= '0;
            illegal <= 1'b0;
        end else begin
            done <= exe.valid; // one pulse per instruction
            if (exe.valid) begin
                rdWrite <= exe.wbSel != wbNone;
                memRead <= exe.memRead;
                storeMask <= exe.storeMask;
                illegal <= exe.illegal;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exe.valid) begin
            rdData <= exe.wordOp ? {{32{wbValue[31]}}, wbValue[31:0]} : wbValue;
            nextPc <= exe.nextPc;
            memAddr <= exe.aluResult; // rs1+imm for loads and stores
            loadSize <= exe.loadSize;
            loadSigned <= exe.loadSigned;
        end
    end

endmodule

`default_nettype wire

// File: execute/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute import isaPkg::*, execPkg::*; (
    input  logic       clk,
    input  logic       reset,
    decodeIf.consumer  dec,
    executeIf.producer exe
);

    logic [xlen-1:0] opA, opB, shiftSrc, result, target, nextPc;
    logic [5:0]      shamt;
    logic            taken;

    assign opA = dec.selPc ? dec.pc : dec.rs1;
    assign opB = dec.selImm ? dec.imm : dec.rs2;
    assign shamt = dec.wordOp ? {1'b0, opB[4:0]} : opB[5:0];
    // word shifts see only the low half, sign filled for sra
    assign shiftSrc = dec.wordOp ? {{32{dec.aluOp == aluSra && opA[31]}}, opA[31:0]} : opA;
    assign target = dec.pc + dec.imm;

    always_comb begin
        case (dec.aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluSll:   result = shiftSrc << shamt;
            aluSlt:   result = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  result = {{(xlen-1){1'b0}}, opA < opB};
            aluXor:   result = opA ^ opB;
            aluSrl:   result = shiftSrc >> shamt;
            aluSra:   result = $signed(shiftSrc) >>> shamt;
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluPassB: result = opB;
            default:  result = opA + opB;
        endcase
    end

    always_comb begin
        case (dec.branch)
            brEq:    taken = dec.rs1 == dec.rs2;
            brNe:    taken = dec.rs1 != dec.rs2;
            brLt:    taken = $signed(dec.rs1) < $signed(dec.rs2);
            brGe:    taken = $signed(dec.rs1) >= $signed(dec.rs2);
            brLtu:   taken = dec.rs1 < dec.rs2;
            brGeu:   taken = dec.rs1 >= dec.rs2;
            brJal:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign nextPc = dec.branch == brJalr ? {result[xlen-1:1], 1'b0}
                  : taken ? target : dec.pc + pcStep;

    always_ff @(posedge clk) begin
        if (reset)
            exe.valid <= 1'b0;
        else
            exe.valid <= dec.valid;
    end

    always_ff @(posedge clk) begin
        if (dec.valid) begin
            exe.aluResult <= result;
            exe.linkValue <= dec.pc + pcStep;
            exe.nextPc <= nextPc;
            exe.wbSel <= dec.wbSel;
            exe.wordOp <= dec.wordOp;
            exe.memRead <= dec.memRead;
            exe.loadSize <= dec.loadSize;
            exe.loadSigned <= dec.loadSigned;
            exe.storeMask <= dec.storeMask;
            exe.illegal <= dec.illegal;
        end
    end

endmodule

`default_nettype wire

// File: decode/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder import isaPkg::*, execPkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    decodeIf.producer       dec
);

    opcodeT                    opcode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [xlen-1:0]           immI, immS, immB, immU, immJ;
    aluOpT                     aluOp;
    logic                      selPc, selImm;
    logic [xlen-1:0]           imm;
    branchT                    branch;
    wbSelT                     wbSel;
    logic                      wordOp, memRead, loadSigned, bad;
    logic [loadSizeWidth-1:0]  loadSize;
    logic [storeMaskWidth-1:0] storeMask;
    logic                      altOk, wordF3;

    function automatic aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            f3AddSub: op = alt ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3Srl:    op = alt ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            f3And:    op = aluAnd;
            default:  op = aluAdd;
        endcase
        return op;
    endfunction

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign altOk  = funct3 == f3AddSub || funct3 == f3Srl; // funct3 that allow altFunct7
    assign wordF3 = altOk || funct3 == f3Sll;

    assign immI = {{52{inst[31]}}, inst[31:20]};
    assign immS = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{32{inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        aluOp = aluAdd;
        selPc = 1'b0;
        selImm = 1'b1;
        imm = immI;
        branch = brNone;
        wbSel = wbNone;
        wordOp = 1'b0;
        memRead = 1'b0;
        loadSize = '0;
        loadSigned = 1'b0;
        storeMask = '0;
        bad = 1'b0;
        case (opcode)
            opOp: begin
                selImm = 1'b0;
                wbSel = wbAlu;
                aluOp = aluFromFunct3(funct3, funct7[5]);
                bad = !(funct7 == zeroFunct7 || (funct7 == altFunct7 && altOk));
            end
            opOpImm: begin
                wbSel = wbAlu;
                aluOp = aluFromFunct3(funct3, funct3 == f3Srl && inst[30]);
                if (funct3 == f3Sll)
                    bad = inst[31:26] != 6'b000000; // 6-bit shamt
                else if (funct3 == f3Srl)
                    bad = inst[31:26] != 6'b000000 && inst[31:26] != 6'b010000;
            end
            opOp32: begin
                selImm = 1'b0;
                wbSel = wbAlu;
                wordOp = 1'b1;
                aluOp = aluFromFunct3(funct3, funct7[5]);
                bad = !((funct7 == zeroFunct7 && wordF3) || (funct7 == altFunct7 && altOk));
            end
            opOpImm32: begin
                wbSel = wbAlu;
                wordOp = 1'b1;
                aluOp = aluFromFunct3(funct3, funct3 == f3Srl && inst[30]);
                bad = !wordF3 || (funct3 != f3AddSub && funct7 != zeroFunct7
                    && !(funct7 == altFunct7 && funct3 == f3Srl));
            end
            opLui: begin
                imm = immU;
                aluOp = aluPassB;
                wbSel = wbAlu;
            end
            opAuipc: begin
                imm = immU;
                selPc = 1'b1;
                wbSel = wbAlu;
            end
            opJal: begin
                imm = immJ;
                selPc = 1'b1;
                branch = brJal;
                wbSel = wbLink;
            end
            opJalr: begin
                branch = brJalr; // alu gives rs1+imm
                wbSel = wbLink;
                bad = funct3 != 3'b000;
            end
            opBranch: begin
                imm = immB;
                case (funct3)
                    f3Beq:   branch = brEq;
                    f3Bne:   branch = brNe;
                    f3Blt:   branch = brLt;
                    f3Bge:   branch = brGe;
                    f3Bltu:  branch = brLtu;
                    f3Bgeu:  branch = brGeu;
                    default: bad = 1'b1;
                endcase
            end
            opLoad: begin
                memRead = 1'b1; // data written back outside
                case (funct3)
                    f3Lb:    {loadSize, loadSigned} = {4'd1, 1'b1};
                    f3Lh:    {loadSize, loadSigned} = {4'd2, 1'b1};
                    f3Lw:    {loadSize, loadSigned} = {4'd4, 1'b1};
                    f3Ld:    {loadSize, loadSigned} = {4'd8, 1'b1};
                    f3Lbu:   loadSize = 4'd1;
                    f3Lhu:   loadSize = 4'd2;
                    f3Lwu:   loadSize = 4'd4;
                    default: bad = 1'b1;
                endcase
            end
            opStore: begin
                imm = immS;
                case (funct3)
                    f3Sb:    storeMask = 8'h01;
                    f3Sh:    storeMask = 8'h03;
                    f3Sw:    storeMask = 8'h0f;
                    f3Sd:    storeMask = 8'hff;
                    default: bad = 1'b1;
                endcase
            end
            default: bad = 1'b1; // system, fence, unknown
        endcase
        if (bad) begin
            wbSel = wbNone;
            branch = brNone;
            memRead = 1'b0;
            loadSize = '0;
            storeMask = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec.valid <= 1'b0;
        else
            dec.valid <= start; // single cycle, follows start
    end

    always_ff @(posedge clk) begin
        if (start) begin
            dec.aluOp <= aluOp;
            dec.selPc <= selPc;
            dec.selImm <= selImm;
            dec.imm <= imm;
            dec.branch <= branch;
            dec.wbSel <= wbSel;
            dec.wordOp <= wordOp;
            dec.memRead <= memRead;
            dec.loadSize <= loadSize;
            dec.loadSigned <= loadSigned;
            dec.storeMask <= storeMask;
            dec.illegal <= bad;
            dec.pc <= pc;
            dec.rs1 <= rs1;
            dec.rs2 <= rs2;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        dec.valid |-> !(dec.illegal && dec.storeMask != '0));

endmodule

`default_nettype wire

// File: logic/handshakeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module handshakeCtrl (
    input  logic clk,
    input  logic reset,
    input  logic req,
    input  logic done,
    output logic start,
    output logic ack
);

    typedef enum logic [1:0] {
        idle,
        busy,
        acknowledge
    } stateT;

    stateT state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            start <= 1'b0;
            ack <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                idle: if (req) begin
                    state <= busy;
                    start <= 1'b1;
                end
                busy: if (done) begin
                    state <= acknowledge;
                    ack <= 1'b1;
                end
                acknowledge: if (!req) begin // requester released
                    state <= idle;
                    ack <= 1'b0;
                end
                default: state <= idle;
            endcase
        end
    end

    // result stage may only finish the instruction we started
    assert property (@(posedge clk) disable iff (reset) done |-> state == busy);

endmodule

`default_nettype wire

// File: common/stageIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf import isaPkg::*, execPkg::*; ();
    logic                      valid;
    aluOpT                     aluOp;
    logic                      selPc;  // operand a is pc
    logic                      selImm; // operand b is imm
    logic [xlen-1:0]           imm;
    branchT                    branch;
    wbSelT                     wbSel;
    logic                      wordOp;
    logic                      memRead;
    logic [loadSizeWidth-1:0]  loadSize;
    logic                      loadSigned;
    logic [storeMaskWidth-1:0] storeMask;
    logic                      illegal;
    logic [xlen-1:0]           pc;
    logic [xlen-1:0]           rs1;
    logic [xlen-1:0]           rs2;

    modport producer (output valid, aluOp, selPc, selImm, imm, branch, wbSel, wordOp,
        memRead, loadSize, loadSigned, storeMask, illegal, pc, rs1, rs2);
    modport consumer (input valid, aluOp, selPc, selImm, imm, branch, wbSel, wordOp,
        memRead, loadSize, loadSigned, storeMask, illegal, pc, rs1, rs2);
endinterface

interface executeIf import isaPkg::*, execPkg::*; ();
    logic                      valid;
    logic [xlen-1:0]           aluResult;
    logic [xlen-1:0]           linkValue;
    logic [xlen-1:0]           nextPc;
    wbSelT                     wbSel;
    logic                      wordOp;
    logic                      memRead;
    logic [loadSizeWidth-1:0]  loadSize;
    logic                      loadSigned;
    logic [storeMaskWidth-1:0] storeMask;
    logic                      illegal;

    modport producer (output valid, aluResult, linkValue, nextPc, wbSel, wordOp,
        memRead, loadSize, loadSigned, storeMask, illegal);
    modport consumer (input valid, aluResult, linkValue, nextPc, wbSel, wordOp,
        memRead, loadSize, loadSigned, storeMask, illegal);
endinterface

`default_nettype wire

// File: common/execPkg.sv
`default_nettype none

package execPkg;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB // lui
    } aluOpT;

    typedef enum logic [1:0] {
        wbAlu,
        wbLink,
        wbNone
    } wbSelT;

    typedef enum logic [3:0] {
        brNone,
        brEq,
        brNe,
        brLt,
        brGe,
        brLtu,
        brGeu,
        brJal,
        brJalr
    } branchT;

    localparam int storeMaskWidth = 8;
    localparam int loadSizeWidth = 4; // bytes, one-hot-ish 1/2/4/8
    localparam logic [63:0] pcStep = 64'd4;

endpackage

`default_nettype wire

// File: common/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int xlen = 64;

    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opOpImm   = 7'b0010011,
        opAuipc   = 7'b0010111,
        opOpImm32 = 7'b0011011,
        opStore   = 7'b0100011,
        opOp      = 7'b0110011,
        opLui     = 7'b0110111,
        opOp32    = 7'b0111011,
        opBranch  = 7'b1100011,
        opJalr    = 7'b1100111,
        opJal     = 7'b1101111
    } opcodeT;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    localparam logic [2:0] f3Lb  = 3'b000;
    localparam logic [2:0] f3Lh  = 3'b001;
    localparam logic [2:0] f3Lw  = 3'b010;
    localparam logic [2:0] f3Ld  = 3'b011;
    localparam logic [2:0] f3Lbu = 3'b100;
    localparam logic [2:0] f3Lhu = 3'b101;
    localparam logic [2:0] f3Lwu = 3'b110;

    localparam logic [2:0] f3Sb = 3'b000;
    localparam logic [2:0] f3Sh = 3'b001;
    localparam logic [2:0] f3Sw = 3'b010;
    localparam logic [2:0] f3Sd = 3'b011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3Srl    = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [6:0] altFunct7  = 7'b0100000; // sub, sra
    localparam logic [6:0] zeroFunct7 = 7'b0000000;

endpackage

`default_nettype wire
